// ==== design/mmioPkg.sv ====
package mmioPkg;

    // ------------------------------------------------------------------------
    // request / response opcodes
    // ------------------------------------------------------------------------
    typedef enum logic [1:0] {
        RD     = 2'b00,
        WR     = 2'b01,
        RD_RSP = 2'b10,
        WR_RSP = 2'b11
    } tOpcode;

    // ------------------------------------------------------------------------
    // address layout
    // ------------------------------------------------------------------------
    localparam int TILE_MSB   = 31;
    localparam int TILE_LSB   = 24;
    localparam int REGION_MSB = 23;
    localparam int REGION_LSB = 22;

    localparam logic [1:0] CR_REGION  = 2'b10;
    localparam logic [1:0] VGA_REGION = 2'b01;

    // cr byte offsets, one word apart
    localparam logic [19:0] CR_SEG7_0   = 20'h0_0000;
    localparam logic [19:0] CR_SEG7_1   = 20'h0_0004;
    localparam logic [19:0] CR_SEG7_2   = 20'h0_0008;
    localparam logic [19:0] CR_SEG7_3   = 20'h0_000C;
    localparam logic [19:0] CR_SEG7_4   = 20'h0_0010;
    localparam logic [19:0] CR_SEG7_5   = 20'h0_0014;
    localparam logic [19:0] CR_LED      = 20'h0_0018;
    localparam logic [19:0] CR_BUTTON_0 = 20'h0_001C;  // read only
    localparam logic [19:0] CR_BUTTON_1 = 20'h0_0020;  // read only
    localparam logic [19:0] CR_SWITCH   = 20'h0_0024;  // read only

    // same request word, seen by the cr file or by the frame memory
    typedef union packed {
        struct packed {
            logic [TILE_MSB-TILE_LSB:0]     tile;
            logic [REGION_MSB-REGION_LSB:0] region;
            logic [1:0]                     unused;
            logic [19:0]                    crOffset;  // byte offset
        } cr;
        struct packed {
            logic [TILE_MSB-TILE_LSB:0]     tile;
            logic [REGION_MSB-REGION_LSB:0] region;
            logic [1:0]                     unused;
            logic [17:0]                    vgaWord;   // word index into frame
            logic [1:0]                     byteSel;   // always full word here
        } vga;
    } tMmioAddr;

endpackage

// ==== design/reqDecode.sv ====
`timescale 1ns/1ps

module reqDecode import mmioPkg::*; #(
    parameter logic [7:0] TILE_ID = 8'd3
) (
    input  logic        QClk,
    input  logic        rstN,
    input  logic        reqValid,     // one-cycle strobe, Q502
    input  tOpcode      reqOpcode,
    input  logic [31:0] reqAddress,
    input  logic [31:0] reqData,
    output tMmioAddr    addrQ503,
    output logic [31:0] dataQ503,
    output tOpcode      opcodeQ503,   // sampled opcode, for probing
    output logic        crRdEn,
    output logic        crWrEn,
    output logic        vgaRdEn,
    output logic        vgaWrEn
);

    logic tileHit;
    logic crHit;
    logic vgaHit;
    logic isRd;
    logic isWr;

    // decode at Q502 so the enables leave as clean flops
    assign tileHit = reqValid && (reqAddress[TILE_MSB:TILE_LSB] == TILE_ID);
    assign crHit   = tileHit && (reqAddress[REGION_MSB:REGION_LSB] == CR_REGION);
    assign vgaHit  = tileHit && (reqAddress[REGION_MSB:REGION_LSB] == VGA_REGION);
    assign isRd    = (reqOpcode == RD);
    assign isWr    = (reqOpcode == WR);    // rsp opcodes on the request side drop

    always_ff @(posedge QClk or negedge rstN) begin
        if (!rstN) begin
            crRdEn  <= 1'b0;
            crWrEn  <= 1'b0;
            vgaRdEn <= 1'b0;
            vgaWrEn <= 1'b0;
        end else begin
            crRdEn  <= crHit && isRd;
            crWrEn  <= crHit && isWr;
            vgaRdEn <= vgaHit && isRd;
            vgaWrEn <= vgaHit && isWr;
        end
    end

    // payload, no reset
    always_ff @(posedge QClk) begin
        addrQ503   <= reqAddress;
        dataQ503   <= reqData;
        opcodeQ503 <= reqOpcode;
    end

    // a strobe carries a known opcode and address
    knownRequest: assert property (@(posedge QClk) disable iff (!rstN)
        reqValid |-> !$isunknown({reqOpcode, reqAddress}));

endmodule

// ==== design/crRegFile.sv ====
`timescale 1ns/1ps

module crRegFile import mmioPkg::*; (
    input  logic        QClk,
    input  logic        rstN,
    input  logic        crRdEn,       // Q503
    input  logic        crWrEn,       // Q503
    input  tMmioAddr    addrQ503,
    input  logic [31:0] dataQ503,
    input  logic        button0,      // raw board inputs
    input  logic        button1,
    input  logic [9:0]  switch,
    output logic [31:0] crRdData,     // Q504
    output logic [7:0]  seg7Out0,
    output logic [7:0]  seg7Out1,
    output logic [7:0]  seg7Out2,
    output logic [7:0]  seg7Out3,
    output logic [7:0]  seg7Out4,
    output logic [7:0]  seg7Out5,
    output logic [9:0]  led
);

    logic [7:0]  seg7Reg [6];
    logic [9:0]  ledReg;
    logic [1:0]  button0Sync;   // two-flop synchronizers
    logic [1:0]  button1Sync;
    logic [9:0]  switchMeta;
    logic [9:0]  switchSync;
    logic [31:0] rdMux;

    // ------------------------------------------------------------------------
    // rw registers
    // ------------------------------------------------------------------------
    always_ff @(posedge QClk or negedge rstN) begin
        if (!rstN) begin
            seg7Reg <= '{default: '0};
            ledReg  <= '0;
        end else if (crWrEn) begin
            case (addrQ503.cr.crOffset)
                CR_SEG7_0: seg7Reg[0] <= dataQ503[7:0];
                CR_SEG7_1: seg7Reg[1] <= dataQ503[7:0];
                CR_SEG7_2: seg7Reg[2] <= dataQ503[7:0];
                CR_SEG7_3: seg7Reg[3] <= dataQ503[7:0];
                CR_SEG7_4: seg7Reg[4] <= dataQ503[7:0];
                CR_SEG7_5: seg7Reg[5] <= dataQ503[7:0];
                CR_LED:    ledReg     <= dataQ503[9:0];
                default: ;  // ro and unmapped offsets, ack only
            endcase
        end
    end

    // board inputs, sampled every cycle
    always_ff @(posedge QClk or negedge rstN) begin
        if (!rstN) begin
            button0Sync <= '0;
            button1Sync <= '0;
            switchMeta  <= '0;
            switchSync  <= '0;
        end else begin
            button0Sync <= {button0Sync[0], button0};
            button1Sync <= {button1Sync[0], button1};
            switchMeta  <= switch;
            switchSync  <= switchMeta;
        end
    end

    // ------------------------------------------------------------------------
    // read path, zero extended
    // ------------------------------------------------------------------------
    always_comb begin
        case (addrQ503.cr.crOffset)
            CR_SEG7_0:   rdMux = {24'b0, seg7Reg[0]};
            CR_SEG7_1:   rdMux = {24'b0, seg7Reg[1]};
            CR_SEG7_2:   rdMux = {24'b0, seg7Reg[2]};
            CR_SEG7_3:   rdMux = {24'b0, seg7Reg[3]};
            CR_SEG7_4:   rdMux = {24'b0, seg7Reg[4]};
            CR_SEG7_5:   rdMux = {24'b0, seg7Reg[5]};
            CR_LED:      rdMux = {22'b0, ledReg};
            CR_BUTTON_0: rdMux = {31'b0, button0Sync[1]};
            CR_BUTTON_1: rdMux = {31'b0, button1Sync[1]};
            CR_SWITCH:   rdMux = {22'b0, switchSync};
            default:     rdMux = '0;  // unmapped
        endcase
    end

    always_ff @(posedge QClk) begin
        if (crRdEn) crRdData <= rdMux;  // hold between reads
    end

    // display pins trail the registers by one edge
    always_ff @(posedge QClk or negedge rstN) begin
        if (!rstN) begin
            seg7Out0 <= '0;
            seg7Out1 <= '0;
            seg7Out2 <= '0;
            seg7Out3 <= '0;
            seg7Out4 <= '0;
            seg7Out5 <= '0;
            led      <= '0;
        end else begin
            seg7Out0 <= seg7Reg[0];
            seg7Out1 <= seg7Reg[1];
            seg7Out2 <= seg7Reg[2];
            seg7Out3 <= seg7Reg[3];
            seg7Out4 <= seg7Reg[4];
            seg7Out5 <= seg7Reg[5];
            led      <= ledReg;
        end
    end

endmodule

// ==== design/vgaFrameMem.sv ====
`timescale 1ns/1ps

module vgaFrameMem import mmioPkg::*; #(
    parameter int VGA_WORDS    = 1200,
    parameter int H_ACTIVE     = 80,
    parameter int H_TOTAL      = 100,
    parameter int H_SYNC_START = 84,
    parameter int H_SYNC_LEN   = 8,
    parameter int V_ACTIVE     = 60,
    parameter int V_TOTAL      = 66,
    parameter int V_SYNC_START = 62,
    parameter int V_SYNC_LEN   = 2
) (
    input  logic        QClk,
    input  logic        rstN,
    input  logic        vgaRdEn,      // Q503
    input  logic        vgaWrEn,      // Q503
    input  tMmioAddr    addrQ503,
    input  logic [31:0] dataQ503,
    output logic [31:0] vgaRdData,    // Q504
    output logic [3:0]  red,
    output logic [3:0]  green,
    output logic [3:0]  blue,
    output logic        hSync,        // active low
    output logic        vSync         // active low
);

    localparam int IDX_W         = $clog2(VGA_WORDS);
    localparam int HC_W          = $clog2(H_TOTAL);
    localparam int VC_W          = $clog2(V_TOTAL);
    localparam int WORDS_PER_ROW = H_ACTIVE / 8;   // 8 pixels per word

    logic [31:0]      frameMem [VGA_WORDS];
    logic             coreInRange;
    logic [IDX_W-1:0] coreIdx;
    logic [HC_W-1:0]  hCount;
    logic [VC_W-1:0]  vCount;
    logic             lineEnd;
    logic             scanActive;
    logic [31:0]      scanFull;
    logic [IDX_W-1:0] scanIdx;
    logic             scanInRange;
    logic [31:0]      pixWord;     // scan port read data
    logic             pixValid;

    // ------------------------------------------------------------------------
    // core port
    // ------------------------------------------------------------------------
    assign coreInRange = (addrQ503.vga.vgaWord < VGA_WORDS);
    assign coreIdx     = addrQ503.vga.vgaWord[IDX_W-1:0];

    always_ff @(posedge QClk) begin
        if (vgaWrEn && coreInRange) frameMem[coreIdx] <= dataQ503;
        if (vgaRdEn) vgaRdData <= coreInRange ? frameMem[coreIdx] : '0;  // oob reads 0
    end

    // ------------------------------------------------------------------------
    // raster scan, one pixel per clock
    // ------------------------------------------------------------------------
    assign lineEnd = (hCount == HC_W'(H_TOTAL - 1));

    always_ff @(posedge QClk or negedge rstN) begin
        if (!rstN) begin
            hCount <= '0;
            vCount <= '0;
        end else if (lineEnd) begin
            hCount <= '0;
            vCount <= (vCount == VC_W'(V_TOTAL - 1)) ? '0 : vCount + 1'b1;
        end else begin
            hCount <= hCount + 1'b1;
        end
    end

    assign scanActive  = (hCount < H_ACTIVE) && (vCount < V_ACTIVE);
    assign scanFull    = 32'(vCount) * 32'(WORDS_PER_ROW) + 32'(hCount >> 3);
    assign scanIdx     = scanFull[IDX_W-1:0];
    assign scanInRange = scanActive && (scanFull < VGA_WORDS);

    always_ff @(posedge QClk) begin
        if (scanInRange) pixWord <= frameMem[scanIdx];  // second read port
    end

    // syncs delayed one edge to line up with pixWord
    always_ff @(posedge QClk or negedge rstN) begin
        if (!rstN) begin
            hSync    <= 1'b1;
            vSync    <= 1'b1;
            pixValid <= 1'b0;
        end else begin
            hSync    <= !((hCount >= H_SYNC_START) && (hCount < H_SYNC_START + H_SYNC_LEN));
            vSync    <= !((vCount >= V_SYNC_START) && (vCount < V_SYNC_START + V_SYNC_LEN));
            pixValid <= scanInRange;
        end
    end

    // low 12 bits as r/g/b, black in blanking
    assign {red, green, blue} = pixValid ? pixWord[11:0] : 12'h000;

    // core accesses need a known word index
    coreAddrKnown: assert property (@(posedge QClk) disable iff (!rstN)
        (vgaRdEn || vgaWrEn) |-> !$isunknown(addrQ503.vga.vgaWord));

endmodule

// ==== design/rspMerge.sv ====
`timescale 1ns/1ps

module rspMerge import mmioPkg::*; (
    input  logic        QClk,
    input  logic        rstN,
    input  logic        crRdEn,       // Q503
    input  logic        crWrEn,
    input  logic        vgaRdEn,
    input  logic        vgaWrEn,
    input  tMmioAddr    addrQ503,
    input  logic [31:0] crRdData,     // Q504
    input  logic [31:0] vgaRdData,    // Q504
    output logic        rspValid,     // Q500
    output tOpcode      rspOpcode,
    output logic [31:0] rspAddress,
    output logic [31:0] rspData
);

    logic        crRdQ504;
    logic        vgaRdQ504;
    logic        anyWrQ504;
    logic [31:0] addrQ504;
    logic        rdQ504;

    // align with read data latency
    always_ff @(posedge QClk or negedge rstN) begin
        if (!rstN) begin
            crRdQ504  <= 1'b0;
            vgaRdQ504 <= 1'b0;
            anyWrQ504 <= 1'b0;
        end else begin
            crRdQ504  <= crRdEn;
            vgaRdQ504 <= vgaRdEn;
            anyWrQ504 <= crWrEn || vgaWrEn;
        end
    end

    always_ff @(posedge QClk) addrQ504 <= addrQ503;

    assign rdQ504 = crRdQ504 || vgaRdQ504;

    // ------------------------------------------------------------------------
    // Q504 -> Q500
    // ------------------------------------------------------------------------
    always_ff @(posedge QClk or negedge rstN) begin
        if (!rstN) rspValid <= 1'b0;
        else       rspValid <= rdQ504 || anyWrQ504;
    end

    always_ff @(posedge QClk) begin
        rspOpcode  <= rdQ504 ? RD_RSP : WR_RSP;
        rspAddress <= addrQ504;
        rspData    <= crRdQ504  ? crRdData  :
                      vgaRdQ504 ? vgaRdData : '0;  // write ack carries zero
    end

    rspValidKnown: assert property (@(posedge QClk) disable iff (!rstN)
        !$isunknown(rspValid));

endmodule

// ==== design/boardMmio.sv ====
`timescale 1ns/1ps

module boardMmio import mmioPkg::*; #(
    parameter logic [7:0] TILE_ID = 8'd3,
    parameter int VGA_WORDS    = 1200,
    parameter int H_ACTIVE     = 80,
    parameter int H_TOTAL      = 100,
    parameter int H_SYNC_START = 84,
    parameter int H_SYNC_LEN   = 8,
    parameter int V_ACTIVE     = 60,
    parameter int V_TOTAL      = 66,
    parameter int V_SYNC_START = 62,
    parameter int V_SYNC_LEN   = 2
) (
    input  logic        QClk,
    input  logic        rstN,
    input  logic        reqValid,     // Q502
    input  tOpcode      reqOpcode,
    input  logic [31:0] reqAddress,
    input  logic [31:0] reqData,
    output logic        rspValid,     // Q500
    output tOpcode      rspOpcode,
    output logic [31:0] rspAddress,
    output logic [31:0] rspData,
    input  logic        button0,
    input  logic        button1,
    input  logic [9:0]  switch,
    output logic [7:0]  seg7Out0,
    output logic [7:0]  seg7Out1,
    output logic [7:0]  seg7Out2,
    output logic [7:0]  seg7Out3,
    output logic [7:0]  seg7Out4,
    output logic [7:0]  seg7Out5,
    output logic [9:0]  led,
    output logic [3:0]  red,
    output logic [3:0]  green,
    output logic [3:0]  blue,
    output logic        hSync,
    output logic        vSync
);

    tMmioAddr    addrQ503;
    logic [31:0] dataQ503;
    logic        crRdEn;
    logic        crWrEn;
    logic        vgaRdEn;
    logic        vgaWrEn;
    logic [31:0] crRdData;     // Q504
    logic [31:0] vgaRdData;    // Q504

    // ------------------------------------------------------------------------
    // Q502 -> Q503
    // ------------------------------------------------------------------------
    reqDecode #(
        .TILE_ID (TILE_ID)
    ) reqDecode_i (
        .QClk       (QClk),
        .rstN       (rstN),
        .reqValid   (reqValid),
        .reqOpcode  (reqOpcode),
        .reqAddress (reqAddress),
        .reqData    (reqData),
        .addrQ503   (addrQ503),
        .dataQ503   (dataQ503),
        .opcodeQ503 (),             // enables already carry rd/wr
        .crRdEn     (crRdEn),
        .crWrEn     (crWrEn),
        .vgaRdEn    (vgaRdEn),
        .vgaWrEn    (vgaWrEn)
    );

    // targets, Q503 -> Q504
    crRegFile crRegFile_i (
        .QClk     (QClk),
        .rstN     (rstN),
        .crRdEn   (crRdEn),
        .crWrEn   (crWrEn),
        .addrQ503 (addrQ503),
        .dataQ503 (dataQ503),
        .button0  (button0),
        .button1  (button1),
        .switch   (switch),
        .crRdData (crRdData),
        .seg7Out0 (seg7Out0),
        .seg7Out1 (seg7Out1),
        .seg7Out2 (seg7Out2),
        .seg7Out3 (seg7Out3),
        .seg7Out4 (seg7Out4),
        .seg7Out5 (seg7Out5),
        .led      (led)
    );

    vgaFrameMem #(
        .VGA_WORDS    (VGA_WORDS),
        .H_ACTIVE     (H_ACTIVE),
        .H_TOTAL      (H_TOTAL),
        .H_SYNC_START (H_SYNC_START),
        .H_SYNC_LEN   (H_SYNC_LEN),
        .V_ACTIVE     (V_ACTIVE),
        .V_TOTAL      (V_TOTAL),
        .V_SYNC_START (V_SYNC_START),
        .V_SYNC_LEN   (V_SYNC_LEN)
    ) vgaFrameMem_i (
        .QClk      (QClk),
        .rstN      (rstN),
        .vgaRdEn   (vgaRdEn),
        .vgaWrEn   (vgaWrEn),
        .addrQ503  (addrQ503),
        .dataQ503  (dataQ503),
        .vgaRdData (vgaRdData),
        .red       (red),
        .green     (green),
        .blue      (blue),
        .hSync     (hSync),
        .vSync     (vSync)
    );

    // response, Q504 -> Q500
    rspMerge rspMerge_i (
        .QClk       (QClk),
        .rstN       (rstN),
        .crRdEn     (crRdEn),
        .crWrEn     (crWrEn),
        .vgaRdEn    (vgaRdEn),
        .vgaWrEn    (vgaWrEn),
        .addrQ503   (addrQ503),
        .crRdData   (crRdData),
        .vgaRdData  (vgaRdData),
        .rspValid   (rspValid),
        .rspOpcode  (rspOpcode),
        .rspAddress (rspAddress),
        .rspData    (rspData)
    );

endmodule

// ==== verification/boardMmioTb.sv ====
`timescale 1ns/1ps

module boardMmioTb import mmioPkg::*; ();

    localparam logic [7:0] TILE_ID = 8'd3;
    localparam int VGA_WORDS    = 1200;
    localparam int H_ACTIVE     = 80;
    localparam int H_TOTAL      = 100;
    localparam int H_SYNC_START = 84;
    localparam int H_SYNC_LEN   = 8;
    localparam int V_ACTIVE     = 60;
    localparam int V_TOTAL      = 66;
    localparam int V_SYNC_START = 62;
    localparam int V_SYNC_LEN   = 2;
    localparam int CLK_PERIOD   = 40;   // ns

    logic        QClk;
    logic        rstN;
    logic        reqValid;
    tOpcode      reqOpcode;
    logic [31:0] reqAddress;
    logic [31:0] reqData;
    logic        rspValid;
    tOpcode      rspOpcode;
    logic [31:0] rspAddress;
    logic [31:0] rspData;
    logic        button0;
    logic        button1;
    logic [9:0]  switch;
    logic [7:0]  seg7Out0;
    logic [7:0]  seg7Out1;
    logic [7:0]  seg7Out2;
    logic [7:0]  seg7Out3;
    logic [7:0]  seg7Out4;
    logic [7:0]  seg7Out5;
    logic [9:0]  led;
    logic [3:0]  red;
    logic [3:0]  green;
    logic [3:0]  blue;
    logic        hSync;
    logic        vSync;

    // pattern table, one entry per file line
    int          patOp [$];
    logic [31:0] patAddr [$];
    logic [31:0] patData [$];
    logic [9:0]  patSwitch [$];
    logic [1:0]  patButton [$];
    int          patRsp [$];
    logic [31:0] patRspData [$];
    int          patCount  = 0;
    bit          patLoaded = 1'b0;
    bit          syncDone  = 1'b0;
    int          cycleNum  = 0;     // counts falling edges after reset

    // responses in flight, oldest first
    int          expDue [$];
    tOpcode      expOp [$];
    logic [31:0] expAddr [$];
    logic [31:0] expData [$];
    logic [31:0] expWrData [$];

    logic [7:0]  seg7Model [6];     // display registers as the core sees them
    logic [9:0]  ledModel;
    logic [11:0] frameModel [int];  // pixel color of each written frame word

    boardMmio #(
        .TILE_ID      (TILE_ID),
        .VGA_WORDS    (VGA_WORDS),
        .H_ACTIVE     (H_ACTIVE),
        .H_TOTAL      (H_TOTAL),
        .H_SYNC_START (H_SYNC_START),
        .H_SYNC_LEN   (H_SYNC_LEN),
        .V_ACTIVE     (V_ACTIVE),
        .V_TOTAL      (V_TOTAL),
        .V_SYNC_START (V_SYNC_START),
        .V_SYNC_LEN   (V_SYNC_LEN)
    ) boardMmio_i (
        .QClk       (QClk),
        .rstN       (rstN),
        .reqValid   (reqValid),
        .reqOpcode  (reqOpcode),
        .reqAddress (reqAddress),
        .reqData    (reqData),
        .rspValid   (rspValid),
        .rspOpcode  (rspOpcode),
        .rspAddress (rspAddress),
        .rspData    (rspData),
        .button0    (button0),
        .button1    (button1),
        .switch     (switch),
        .seg7Out0   (seg7Out0),
        .seg7Out1   (seg7Out1),
        .seg7Out2   (seg7Out2),
        .seg7Out3   (seg7Out3),
        .seg7Out4   (seg7Out4),
        .seg7Out5   (seg7Out5),
        .led        (led),
        .red        (red),
        .green      (green),
        .blue       (blue),
        .hSync      (hSync),
        .vSync      (vSync)
    );

    initial QClk = 1'b0;
    always #(CLK_PERIOD / 2) QClk = ~QClk;

    // ------------------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------------------
    task automatic reportMismatch(input string name, input logic [31:0] expVal,
                                  input logic [31:0] actVal);
        $display("[ERROR] %0t ns %s expected %h got %h", $time, name, expVal, actVal);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic checkRsp(input logic expValid, input tOpcode expOpcode,
                            input logic [31:0] expAddress, input logic [31:0] expRspData);
        if (rspValid !== expValid)
            reportMismatch("rspValid", {31'b0, expValid}, {31'b0, rspValid});
        if (expValid) begin
            if (rspOpcode !== expOpcode)
                reportMismatch("rspOpcode", {30'b0, expOpcode}, {30'b0, rspOpcode});
            if (rspAddress !== expAddress)
                reportMismatch("rspAddress", expAddress, rspAddress);
            if (rspData !== expRspData)
                reportMismatch("rspData", expRspData, rspData);
        end
    endtask

    task automatic checkDisplay();
        if (seg7Out0 !== seg7Model[0]) reportMismatch("seg7Out0", 32'(seg7Model[0]), 32'(seg7Out0));
        if (seg7Out1 !== seg7Model[1]) reportMismatch("seg7Out1", 32'(seg7Model[1]), 32'(seg7Out1));
        if (seg7Out2 !== seg7Model[2]) reportMismatch("seg7Out2", 32'(seg7Model[2]), 32'(seg7Out2));
        if (seg7Out3 !== seg7Model[3]) reportMismatch("seg7Out3", 32'(seg7Model[3]), 32'(seg7Out3));
        if (seg7Out4 !== seg7Model[4]) reportMismatch("seg7Out4", 32'(seg7Model[4]), 32'(seg7Out4));
        if (seg7Out5 !== seg7Model[5]) reportMismatch("seg7Out5", 32'(seg7Model[5]), 32'(seg7Out5));
        if (led !== ledModel) reportMismatch("led", 32'(ledModel), 32'(led));
    endtask

    task automatic checkColor(input logic [11:0] expRgb);
        if ({red, green, blue} !== expRgb)
            reportMismatch("rgb", 32'(expRgb), 32'({red, green, blue}));
    endtask

    task automatic checkSpacing(input string name, input int expCycles, input int actCycles);
        if (actCycles != expCycles) reportMismatch(name, 32'(expCycles), 32'(actCycles));
    endtask

    // display offsets of this tile's cr region and in-range frame words land in the models
    task automatic updateModel(input logic [31:0] addr, input logic [31:0] data);
        if (addr[TILE_MSB:TILE_LSB] == TILE_ID && addr[REGION_MSB:REGION_LSB] == CR_REGION) begin
            case (addr[19:0])
                CR_SEG7_0: seg7Model[0] = data[7:0];
                CR_SEG7_1: seg7Model[1] = data[7:0];
                CR_SEG7_2: seg7Model[2] = data[7:0];
                CR_SEG7_3: seg7Model[3] = data[7:0];
                CR_SEG7_4: seg7Model[4] = data[7:0];
                CR_SEG7_5: seg7Model[5] = data[7:0];
                CR_LED:    ledModel     = data[9:0];
                default: ;
            endcase
        end else if (addr[TILE_MSB:TILE_LSB] == TILE_ID
                     && addr[REGION_MSB:REGION_LSB] == VGA_REGION
                     && addr[19:2] < VGA_WORDS) begin
            frameModel[int'(addr[19:2])] = data[11:0];   // word index above byteSel
        end
    endtask

    // ------------------------------------------------------------------------
    // pattern file and per-cycle drive / check
    // ------------------------------------------------------------------------
    task automatic loadPatterns();
        int          fd;
        int          n;
        string       line;
        int          op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] sw;
        logic [31:0] btn;
        int          rsp;
        logic [31:0] rspWord;
        fd = $fopen("verification/mmioPatterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open verification/mmioPatterns.txt");
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 0 && line[0] != "#") begin   // skip column notes
                n = $sscanf(line, "%d %h %h %h %h %d %h", op, addr, data, sw, btn, rsp, rspWord);
                if (n == 7) begin
                    patOp.push_back(op);
                    patAddr.push_back(addr);
                    patData.push_back(data);
                    patSwitch.push_back(sw[9:0]);
                    patButton.push_back(btn[1:0]);
                    patRsp.push_back(rsp);
                    patRspData.push_back(rspWord);
                end
            end
        end
        $fclose(fd);
        patCount = patOp.size();
    endtask

    task automatic driveRequest(input int idx);
        reqValid           = (patOp[idx] != 2);   // 2 is an idle line
        reqOpcode          = (patOp[idx] == 1) ? WR : RD;
        reqAddress         = patAddr[idx];
        reqData            = patData[idx];
        switch             = patSwitch[idx];
        {button1, button0} = patButton[idx];
        if (patRsp[idx] != 0) begin
            expDue.push_back(cycleNum + 3);        // three cycles after the strobe
            expOp.push_back((patOp[idx] == 1) ? WR_RSP : RD_RSP);
            expAddr.push_back(patAddr[idx]);
            expData.push_back(patRspData[idx]);
            expWrData.push_back(patData[idx]);
        end
    endtask

    // outputs here come from the rising edge just before
    task automatic checkCycle();
        cycleNum++;
        if (expDue.size() > 0 && expDue[0] == cycleNum) begin
            if (expOp[0] == WR_RSP) updateModel(expAddr[0], expWrData[0]);  // pins move with ack
            checkRsp(1'b1, expOp[0], expAddr[0], expData[0]);
            void'(expDue.pop_front());
            void'(expOp.pop_front());
            void'(expAddr.pop_front());
            void'(expData.pop_front());
            void'(expWrData.pop_front());
        end else begin
            checkRsp(1'b0, RD_RSP, '0, '0);   // dropped or idle, nothing may come back
        end
        checkDisplay();
    endtask

    initial begin : stimulus
        int i;
        rstN       = 1'b0;
        reqValid   = 1'b0;
        reqOpcode  = RD;
        reqAddress = '0;
        reqData    = '0;
        button0    = 1'b0;
        button1    = 1'b0;
        switch     = '0;
        seg7Model  = '{default: '0};
        ledModel   = '0;
        loadPatterns();
        patLoaded = 1'b1;
        repeat (5) @(posedge QClk);
        @(negedge QClk);
        rstN = 1'b1;
        for (i = 0; i < patCount; i++) begin
            @(negedge QClk);
            checkCycle();
            driveRequest(i);
        end
        while (expDue.size() > 0) begin     // drain the pipe
            @(negedge QClk);
            checkCycle();
            reqValid = 1'b0;
        end
        wait (syncDone);
        if (patCount == 0) begin
            $display("no request patterns were read");
            $display("TESTBENCH FAILED");
            $fatal(1);
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // sync timing and pixel color, two vsync falls cover one full frame
    // ------------------------------------------------------------------------
    initial begin : syncCheck
        int   cyc;
        int   lastHFall;
        int   lastVFall;
        int   vFalls;
        int   pix;
        int   hPos;
        int   vPos;
        int   wordIdx;
        logic hPrev;
        logic vPrev;
        cyc       = 0;
        lastHFall = -1;
        lastVFall = -1;
        vFalls    = 0;
        hPrev     = 1'b1;
        vPrev     = 1'b1;
        wait (rstN === 1'b1);
        while (vFalls < 2) begin
            @(negedge QClk);
            cyc++;
            pix  = cyc - 1;                       // pins show the position one edge back
            hPos = pix % H_TOTAL;
            vPos = (pix / H_TOTAL) % V_TOTAL;
            if (hPos < H_ACTIVE && vPos < V_ACTIVE) begin
                wordIdx = vPos * (H_ACTIVE / 8) + hPos / 8;   // 8 pixels share a word
                if (frameModel.exists(wordIdx)) checkColor(frameModel[wordIdx]);
            end else begin
                checkColor(12'h000);              // blanking is black
            end
            if (hPrev && !hSync) begin
                if (lastHFall >= 0) checkSpacing("hSync period", H_TOTAL, cyc - lastHFall);
                lastHFall = cyc;
            end
            if (!hPrev && hSync) checkSpacing("hSync low time", H_SYNC_LEN, cyc - lastHFall);
            if (vPrev && !vSync) begin
                if (lastVFall >= 0)
                    checkSpacing("vSync period", H_TOTAL * V_TOTAL, cyc - lastVFall);
                lastVFall = cyc;
                vFalls++;
            end
            hPrev = hSync;
            vPrev = vSync;
        end
        syncDone = 1'b1;
    end

    initial begin : watchdog
        wait (patLoaded);
        #((patCount + 2 * H_TOTAL * V_TOTAL + 100) * CLK_PERIOD);
        $display("watchdog expired, the responses or the frame did not finish");
        $display("TESTBENCH FAILED");
        $fatal(1);
    end

endmodule

// ==== verification/mmioPatterns.txt ====
# op(0 rd, 1 wr, 2 idle) address wrData switch buttons(b1b0) rspExpected rspData
# all fields hex except op and rspExpected
1 03800000 123456ab 000 0 1 00000000
1 03800004 00000011 000 0 1 00000000
1 03800008 00000022 000 0 1 00000000
1 0380000c 00000033 000 0 1 00000000
1 03800010 00000044 000 0 1 00000000
1 03800014 ffffff55 000 0 1 00000000
1 03800018 ffffffff 000 0 1 00000000
0 03800000 00000000 000 0 1 000000ab
0 03800004 00000000 000 0 1 00000011
0 03800008 00000000 000 0 1 00000022
0 0380000c 00000000 000 0 1 00000033
0 03800010 00000000 000 0 1 00000044
0 03800014 00000000 000 0 1 00000055
0 03800018 00000000 000 0 1 000003ff
2 00000000 00000000 2a5 2 0 00000000
2 00000000 00000000 2a5 2 0 00000000
2 00000000 00000000 2a5 2 0 00000000
0 03800024 00000000 2a5 2 1 000002a5
0 0380001c 00000000 2a5 2 1 00000000
0 03800020 00000000 2a5 2 1 00000001
1 03800024 000000ff 2a5 2 1 00000000
0 03800024 00000000 2a5 2 1 000002a5
1 03400000 00000abc 2a5 2 1 00000000
1 034012bc 00000fed 2a5 2 1 00000000
1 03400040 0000dead 2a5 2 1 00000000
0 03400000 00000000 2a5 2 1 00000abc
0 034012bc 00000000 2a5 2 1 00000fed
0 034012c0 00000000 2a5 2 1 00000000
1 04800000 00000001 2a5 2 0 00000000
0 03800004 00000000 2a5 2 1 00000011
0 03000000 00000000 2a5 2 0 00000000
1 03c00004 00000077 2a5 2 0 00000000
0 03400040 00000000 2a5 2 1 0000dead

// ==== src.f ====
design/mmioPkg.sv
design/reqDecode.sv
design/crRegFile.sv
design/vgaFrameMem.sv
design/rspMerge.sv
design/boardMmio.sv
verification/boardMmioTb.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module boardMmioTb -f src.f -o simBoardMmio

run: compile
	./obj_dir/simBoardMmio | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
